// File: rtl/ps2_pkg.sv
// PS/2 shared definitions
package ps2_pkg;

   localparam int PS2_FRAME_BITS = 11;      // Start, 8 data, parity, stop

   localparam logic [7:0] PS2_CMD_ENABLE   = 8'hF4;
   localparam logic [7:0] PS2_ACK_BYTE     = 8'hFA;
   localparam logic [7:0] PS2_PREFIX_EXT   = 8'hE0;
   localparam logic [7:0] PS2_PREFIX_BREAK = 8'hF0;

   // Keyboard result word
   typedef struct packed {
      logic       ext;      // E0 seen
      logic       brk;      // F0 seen
      logic [5:0] zero;
      logic [7:0] code;
   } key_word_t;

   // Mouse result
   typedef struct packed {
      logic [2:0]  buttons; // Left, middle, right
      logic [11:0] x;
      logic [11:0] y;
   } mouse_state_t;

endpackage

// File: rtl/ps2_line_if.sv
// PS/2 line bundle
`timescale 1ns/1ps
interface ps2_line_if;

   logic clk_in;    // Sampled pins
   logic data_in;
   logic clk_out;   // 0 pulls the line low
   logic data_out;
   logic dir;       // High while the host drives

   modport host (
      input  clk_in,
      input  data_in,
      output clk_out,
      output data_out,
      output dir
   );

   modport monitor (
      input clk_in,
      input data_in,
      input clk_out,
      input data_out,
      input dir
   );

endinterface

// File: rtl/ps2_frame_rx.sv
// PS/2 frame receiver
`timescale 1ns/1ps
module ps2_frame_rx
   import ps2_pkg::*;
#(
   parameter int FILTER_LEN = 8
)
(
   input  logic       clk,
   input  logic       reset,
   input  logic       ps2_clk,
   input  logic       ps2_data,
   input  logic       rx_disable,
   output logic [7:0] rx_byte,
   output logic       strobe,
   output logic       frame_err
);

   localparam int CNT_W = $clog2(FILTER_LEN + 1);
   localparam logic [3:0] LAST_BIT = 4'(PS2_FRAME_BITS - 1);

   logic [1:0]                clk_sync;
   logic [1:0]                data_sync;
   logic                      clk_filt;
   logic [CNT_W-1:0]          filt_cnt;
   logic                      fall;
   logic [3:0]                bit_cnt;
   logic [PS2_FRAME_BITS-1:0] shift_reg;
   logic [PS2_FRAME_BITS-1:0] frame_next;
   logic                      frame_ok;

   // New low level accepted this cycle
   assign fall = clk_filt && !clk_sync[1] && (filt_cnt == CNT_W'(FILTER_LEN - 1));

   assign frame_next = {data_sync[1], shift_reg[PS2_FRAME_BITS-1:1]};
   assign frame_ok = !frame_next[0]                      // Start
                     && frame_next[PS2_FRAME_BITS-1]     // Stop
                     && (^frame_next[9:1]);              // Odd parity over data

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         clk_sync  <= 2'b11;
         data_sync <= 2'b11;
         clk_filt  <= 1'b1;
         filt_cnt  <= '0;
      end
      else
      begin
         clk_sync  <= {clk_sync[0], ps2_clk};
         data_sync <= {data_sync[0], ps2_data};
         if (clk_sync[1] == clk_filt)
            filt_cnt <= '0;                    // Glitch or steady level
         else if (filt_cnt == CNT_W'(FILTER_LEN - 1))
         begin
            clk_filt <= clk_sync[1];
            filt_cnt <= '0;
         end
         else
            filt_cnt <= filt_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         bit_cnt   <= '0;
         strobe    <= 1'b0;
         frame_err <= 1'b0;
      end
      else
      begin
         strobe    <= 1'b0;
         frame_err <= 1'b0;
         if (rx_disable)
            bit_cnt <= '0;                     // Host owns the line
         else if (fall)
         begin
            if (bit_cnt == LAST_BIT)
            begin
               bit_cnt   <= '0;
               strobe    <= frame_ok;
               frame_err <= !frame_ok;
            end
            else
               bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   // Data path
   always_ff @(posedge clk)
   begin
      if (fall && !rx_disable)
      begin
         shift_reg <= frame_next;
         if (bit_cnt == LAST_BIT)
            rx_byte <= frame_next[8:1];
      end
   end

   a_strobe_err_excl: assert property (@(posedge clk) disable iff (reset)
      !(strobe && frame_err));

endmodule

// File: rtl/ps2_keyboard.sv
// PS/2 keyboard decoder
`timescale 1ns/1ps
module ps2_keyboard
   import ps2_pkg::*;
#(
   parameter int FILTER_LEN = 8
)
(
   input  logic      clk,
   input  logic      reset,
   input  logic      ps2_clk,
   input  logic      ps2_data,
   output key_word_t key,
   output logic      strobe
);

   logic [7:0] rx_byte;
   logic       rx_strobe;
   logic       rx_err;
   logic       ext_held;
   logic       brk_held;

   ps2_frame_rx #(
      .FILTER_LEN (FILTER_LEN)
   ) frame_rx_i (
      .clk        (clk),
      .reset      (reset),
      .ps2_clk    (ps2_clk),
      .ps2_data   (ps2_data),
      .rx_disable (1'b0),             // Receive only
      .rx_byte    (rx_byte),
      .strobe     (rx_strobe),
      .frame_err  (rx_err)
   );

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ext_held <= 1'b0;
         brk_held <= 1'b0;
         strobe   <= 1'b0;
      end
      else
      begin
         strobe <= 1'b0;
         if (rx_err)
         begin
            ext_held <= 1'b0;          // Drop a half-built sequence
            brk_held <= 1'b0;
         end
         else if (rx_strobe)
         begin
            if (rx_byte == PS2_PREFIX_EXT)
               ext_held <= 1'b1;
            else if (rx_byte == PS2_PREFIX_BREAK)
               brk_held <= 1'b1;
            else
            begin
               strobe   <= 1'b1;
               ext_held <= 1'b0;
               brk_held <= 1'b0;
            end
         end
      end
   end

   // Key word payload
   always_ff @(posedge clk)
   begin
      if (rx_strobe && !rx_err)
      begin
         key.ext  <= ext_held;
         key.brk  <= brk_held;
         key.zero <= '0;
         key.code <= rx_byte;
      end
   end

   a_flags_clear: assert property (@(posedge clk) disable iff (reset)
      strobe |-> (!ext_held && !brk_held));

endmodule

// File: rtl/ps2_mouse_tx.sv
// PS/2 mouse command transmitter
`timescale 1ns/1ps
module ps2_mouse_tx
   import ps2_pkg::*;
#(
   parameter int FILTER_LEN     = 8,
   parameter int INHIBIT_CYCLES = 10000
)
(
   input  logic   clk,
   input  logic   reset,
   ps2_line_if.host line,
   output logic   done
);

   localparam int CNT_W = $clog2(FILTER_LEN + 1);
   localparam int INH_W = $clog2(INHIBIT_CYCLES + 1);

   typedef enum logic [2:0] {
      ST_INHIBIT,
      ST_REQUEST,
      ST_SHIFT,
      ST_ACK,
      ST_DONE
   } tx_state_t;

   tx_state_t        state;
   logic [INH_W-1:0] inh_cnt;
   logic [1:0]       clk_sync;
   logic [1:0]       data_sync;
   logic             clk_filt;
   logic [CNT_W-1:0] filt_cnt;
   logic             fall;
   logic [8:0]       tx_shift;       // Parity over command
   logic [3:0]       bit_cnt;

   assign fall = clk_filt && !clk_sync[1] && (filt_cnt == CNT_W'(FILTER_LEN - 1));

   // Device clock filter
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         clk_sync  <= 2'b11;
         data_sync <= 2'b11;
         clk_filt  <= 1'b1;
         filt_cnt  <= '0;
      end
      else
      begin
         clk_sync  <= {clk_sync[0], line.clk_in};
         data_sync <= {data_sync[0], line.data_in};
         if (clk_sync[1] == clk_filt)
            filt_cnt <= '0;
         else if (filt_cnt == CNT_W'(FILTER_LEN - 1))
         begin
            clk_filt <= clk_sync[1];
            filt_cnt <= '0;
         end
         else
            filt_cnt <= filt_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= ST_INHIBIT;
         inh_cnt       <= '0;
         tx_shift      <= {~^PS2_CMD_ENABLE, PS2_CMD_ENABLE};
         bit_cnt       <= '0;
         line.dir      <= 1'b1;       // Host holds the clock low
         line.clk_out  <= 1'b0;
         line.data_out <= 1'b1;
         done          <= 1'b0;
      end
      else
      begin
         case (state)
            ST_INHIBIT:
               if (inh_cnt == INH_W'(INHIBIT_CYCLES - 1))
               begin
                  line.data_out <= 1'b0;   // Start bit
                  state         <= ST_REQUEST;
               end
               else
                  inh_cnt <= inh_cnt + 1'b1;
            ST_REQUEST:
            begin
               line.clk_out <= 1'b1;       // Device starts clocking
               state        <= ST_SHIFT;
            end
            ST_SHIFT:
               if (fall)
               begin
                  if (bit_cnt == 4'd9)
                  begin
                     line.data_out <= 1'b1; // Stop bit, line released
                     line.dir      <= 1'b0;
                     state         <= ST_ACK;
                  end
                  else
                  begin
                     line.data_out <= tx_shift[0];
                     tx_shift      <= {1'b0, tx_shift[8:1]};
                     bit_cnt       <= bit_cnt + 1'b1;
                  end
               end
            ST_ACK:
               if (fall && !data_sync[1])
               begin
                  done  <= 1'b1;
                  state <= ST_DONE;
               end
            default: ;                     // Stays idle until reset
         endcase
      end
   end

   a_done_released: assert property (@(posedge clk) disable iff (reset)
      done |-> !line.dir);

endmodule

// File: rtl/ps2_mouse.sv
// PS/2 mouse packet decoder
`timescale 1ns/1ps
module ps2_mouse
   import ps2_pkg::*;
#(
   parameter int FILTER_LEN     = 8,
   parameter int INHIBIT_CYCLES = 10000
)
(
   input  logic         clk,
   input  logic         reset,
   ps2_line_if.host     line,
   output mouse_state_t state,
   output logic         strobe
);

   logic       tx_done;
   logic [7:0] rx_byte;
   logic       rx_strobe;
   logic       rx_err;
   logic       ack_pending;    // First byte after the command
   logic [1:0] byte_idx;
   logic [7:0] byte0;
   logic [7:0] byte1;
   logic [11:0] dx;
   logic [11:0] dy;

   ps2_mouse_tx #(
      .FILTER_LEN     (FILTER_LEN),
      .INHIBIT_CYCLES (INHIBIT_CYCLES)
   ) mouse_tx_i (
      .clk   (clk),
      .reset (reset),
      .line  (line),
      .done  (tx_done)
   );

   ps2_frame_rx #(
      .FILTER_LEN (FILTER_LEN)
   ) frame_rx_i (
      .clk        (clk),
      .reset      (reset),
      .ps2_clk    (line.clk_in),
      .ps2_data   (line.data_in),
      .rx_disable (!tx_done),
      .rx_byte    (rx_byte),
      .strobe     (rx_strobe),
      .frame_err  (rx_err)
   );

   // 9-bit signed deltas, sign extended to the position width
   assign dx = {{4{byte0[4]}}, byte1};
   assign dy = {{4{byte0[5]}}, rx_byte};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack_pending <= 1'b1;
         byte_idx    <= '0;
         state       <= '0;
         strobe      <= 1'b0;
      end
      else
      begin
         strobe <= 1'b0;
         if (rx_err)
            byte_idx <= '0;               // Resync on a bad frame
         else if (rx_strobe)
         begin
            ack_pending <= 1'b0;
            if (!(ack_pending && rx_byte == PS2_ACK_BYTE))
            begin
               case (byte_idx)
                  2'd0:
                     if (rx_byte[3])
                        byte_idx <= 2'd1; // Sync bit set
                  2'd1:
                     byte_idx <= 2'd2;
                  default:
                  begin
                     byte_idx      <= 2'd0;
                     state.buttons <= {byte0[0], byte0[2], byte0[1]};
                     state.x       <= state.x + dx;   // Wraps at 4096
                     state.y       <= state.y + dy;
                     strobe        <= 1'b1;
                  end
               endcase
            end
         end
      end
   end

   // Packet bytes held for assembly
   always_ff @(posedge clk)
   begin
      if (rx_strobe && !rx_err)
      begin
         if (byte_idx == 2'd0)
            byte0 <= rx_byte;
         if (byte_idx == 2'd1)
            byte1 <= rx_byte;
      end
   end

   a_idx_range: assert property (@(posedge clk) disable iff (reset)
      byte_idx <= 2'd2);

endmodule

// File: rtl/ps2_result_reg.sv
// Host result register
`timescale 1ns/1ps
module ps2_result_reg #(
   parameter type payload_t = logic
)
(
   input  logic     clk,
   input  logic     reset,
   input  payload_t in_data,
   input  logic     in_strobe,
   output payload_t out_data,
   output logic     ready
);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         out_data <= '0;
         ready    <= 1'b0;
      end
      else
      begin
         ready <= in_strobe;          // One-cycle pulse
         if (in_strobe)
            out_data <= in_data;      // Held until the next result
      end
   end

endmodule

// File: rtl/ps2_support.sv
// PS/2 input subsystem
`timescale 1ns/1ps
module ps2_support
   import ps2_pkg::*;
#(
   parameter int FILTER_LEN     = 8,
   parameter int INHIBIT_CYCLES = 10000
)
(
   input  logic        clk,
   input  logic        reset,
   input  logic        kb_ps2_clk_in,
   input  logic        kb_ps2_data_in,
   output logic [15:0] kb_data,
   output logic        kb_ready,
   input  logic        ms_ps2_clk_in,
   input  logic        ms_ps2_data_in,
   output logic        ms_ps2_clk_out,
   output logic        ms_ps2_data_out,
   output logic        ms_ps2_dir,
   output logic [11:0] ms_x,
   output logic [11:0] ms_y,
   output logic [2:0]  ms_button,
   output logic        ms_ready
);

   key_word_t    kb_key;
   key_word_t    kb_word;
   logic         kb_strobe;
   mouse_state_t ms_state;
   mouse_state_t ms_word;
   logic         ms_strobe;

   ps2_line_if ms_line();

   assign ms_line.clk_in  = ms_ps2_clk_in;
   assign ms_line.data_in = ms_ps2_data_in;
   assign ms_ps2_clk_out  = ms_line.clk_out;
   assign ms_ps2_data_out = ms_line.data_out;
   assign ms_ps2_dir      = ms_line.dir;

   // Keyboard path
   ps2_keyboard #(
      .FILTER_LEN (FILTER_LEN)
   ) keyboard_i (
      .clk      (clk),
      .reset    (reset),
      .ps2_clk  (kb_ps2_clk_in),
      .ps2_data (kb_ps2_data_in),
      .key      (kb_key),
      .strobe   (kb_strobe)
   );

   ps2_result_reg #(
      .payload_t (key_word_t)
   ) kb_result_i (
      .clk       (clk),
      .reset     (reset),
      .in_data   (kb_key),
      .in_strobe (kb_strobe),
      .out_data  (kb_word),
      .ready     (kb_ready)
   );

   assign kb_data = kb_word;

   // Mouse path
   ps2_mouse #(
      .FILTER_LEN     (FILTER_LEN),
      .INHIBIT_CYCLES (INHIBIT_CYCLES)
   ) mouse_i (
      .clk    (clk),
      .reset  (reset),
      .line   (ms_line.host),
      .state  (ms_state),
      .strobe (ms_strobe)
   );

   ps2_result_reg #(
      .payload_t (mouse_state_t)
   ) ms_result_i (
      .clk       (clk),
      .reset     (reset),
      .in_data   (ms_state),
      .in_strobe (ms_strobe),
      .out_data  (ms_word),
      .ready     (ms_ready)
   );

   assign ms_x      = ms_word.x;
   assign ms_y      = ms_word.y;
   assign ms_button = ms_word.buttons;

endmodule

// File: tests/ps2_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
module ps2_clock_gen #(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 2
)
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Released just after a rising edge
   initial
   begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 reset = 1'b0;
   end

endmodule

// File: tests/ps2_device_tasks.svh
// PS/2 device model tasks
`ifndef PS2_DEVICE_TASKS_SVH
`define PS2_DEVICE_TASKS_SVH

// Lands 1 ns after a rising edge
task automatic wait_cycles(input int n);
   repeat (n) @(posedge clk);
   #1;
endtask

task automatic drive_clk(input bit to_mouse, input logic level);
   if (to_mouse)
      ms_clk = level;
   else
      kb_clk = level;
endtask

task automatic drive_data(input bit to_mouse, input logic level);
   if (to_mouse)
      ms_dat = level;
   else
      kb_dat = level;
endtask

// Device-to-host frame, host samples on the falling edge
task automatic send_frame(input bit to_mouse, input logic [7:0] value, input bit bad_parity);
   logic [10:0] frame;
   int          i;
   frame = {1'b1, (~^value) ^ bad_parity, value, 1'b0};
   for (i = 0; i < 11; i++)
   begin
      drive_data(to_mouse, frame[i]);
      wait_cycles(HALF_CYCLES / 2);
      drive_clk(to_mouse, 1'b0);
      wait_cycles(HALF_CYCLES);
      drive_clk(to_mouse, 1'b1);
      wait_cycles(HALF_CYCLES / 2);
   end
   wait_cycles(HALF_CYCLES);            // Idle gap
endtask

// Host-to-device command, device reads on the rising edge
task automatic receive_command(output logic [9:0] bits);
   int i;
   while (ms_ps2_clk_out !== 1'b1)
      wait_cycles(1);
   wait_cycles(HALF_CYCLES);
   for (i = 0; i < 10; i++)
   begin
      ms_clk = 1'b0;
      wait_cycles(HALF_CYCLES);
      ms_clk = 1'b1;
      bits[i] = ms_ps2_data_out;
      wait_cycles(HALF_CYCLES);
   end
endtask

task automatic send_ack();
   ms_dat = 1'b0;                       // Data low during one clock pulse
   wait_cycles(HALF_CYCLES / 2);
   ms_clk = 1'b0;
   wait_cycles(HALF_CYCLES);
   ms_clk = 1'b1;
   wait_cycles(HALF_CYCLES / 2);
   ms_dat = 1'b1;
   wait_cycles(HALF_CYCLES);
endtask

`endif

// File: tests/tb_ps2_support.sv
// PS/2 subsystem testbench
`timescale 1ns/1ps
module tb_ps2_support;

   localparam int FILTER_LEN     = 4;
   localparam int INHIBIT_CYCLES = 40;
   localparam int HALF_CYCLES    = 20;          // Device clock half period
   localparam int BIT_CYCLES     = 2 * HALF_CYCLES;
   localparam int NUM_FRAMES     = 55;          // Command, ack, keyboard and mouse frames
   localparam int TIMEOUT_CYCLES = NUM_FRAMES * (11 * BIT_CYCLES + HALF_CYCLES)
                                   + INHIBIT_CYCLES + 4000;
   localparam int RAND_SEED      = 76205;

   localparam logic [7:0] ENABLE_CMD = 8'hF4;
   localparam logic [7:0] ACK_BYTE   = 8'hFA;
   localparam logic [7:0] EXT_PREFIX = 8'hE0;
   localparam logic [7:0] BRK_PREFIX = 8'hF0;

   logic        clk;
   logic        reset;
   logic        kb_clk;
   logic        kb_dat;
   logic        ms_clk;
   logic        ms_dat;
   logic [15:0] kb_data;
   logic        kb_ready;
   logic        ms_ps2_clk_out;
   logic        ms_ps2_data_out;
   logic        ms_ps2_dir;
   logic [11:0] ms_x;
   logic [11:0] ms_y;
   logic [2:0]  ms_button;
   logic        ms_ready;

   logic [15:0] kb_expect[$];
   logic [26:0] ms_expect[$];       // Buttons, x, y
   logic [15:0] exp_word;
   logic [26:0] exp_state;
   int          exp_x = 0;
   int          exp_y = 0;
   int          cycle_cnt = 0;
   string       test_name = "reset";

   `include "ps2_device_tasks.svh"

   ps2_clock_gen #(
      .PERIOD_NS    (10),
      .RESET_CYCLES (2)
   ) clock_gen_i (
      .clk   (clk),
      .reset (reset)
   );

   ps2_support #(
      .FILTER_LEN     (FILTER_LEN),
      .INHIBIT_CYCLES (INHIBIT_CYCLES)
   ) ps2_support_i (
      .clk             (clk),
      .reset           (reset),
      .kb_ps2_clk_in   (kb_clk),
      .kb_ps2_data_in  (kb_dat),
      .kb_data         (kb_data),
      .kb_ready        (kb_ready),
      .ms_ps2_clk_in   (ms_clk),
      .ms_ps2_data_in  (ms_dat),
      .ms_ps2_clk_out  (ms_ps2_clk_out),
      .ms_ps2_data_out (ms_ps2_data_out),
      .ms_ps2_dir      (ms_ps2_dir),
      .ms_x            (ms_x),
      .ms_y            (ms_y),
      .ms_button       (ms_button),
      .ms_ready        (ms_ready)
   );

   task automatic halt_run();
      $display(">>> FAIL");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_failed(input string what);
      $display("Error: %s", what);
      halt_run();
   endtask

   task automatic value_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
      $display("Fail %s: expected 0x%0h actual 0x%0h", test, expected, actual);
      halt_run();
   endtask

   function automatic logic [7:0] random_code();
      return 8'(1 + ($urandom % 127));   // Never a prefix byte
   endfunction

   function automatic int random_delta();
      return int'($urandom % 512) - 256;
   endfunction

   task automatic send_key(input bit ext, input bit brk, input logic [7:0] code);
      if (ext)
         send_frame(1'b0, EXT_PREFIX, 1'b0);
      if (brk)
         send_frame(1'b0, BRK_PREFIX, 1'b0);
      kb_expect.push_back({ext, brk, 6'b000000, code});
      send_frame(1'b0, code, 1'b0);
      assert (kb_expect.size() == 0)
      else check_failed("key word was not reported on kb_ready");
   endtask

   // Byte 0 holds Y sign, X sign, sync, middle, right and left from bit 5 down
   task automatic send_packet(input int dx, input int dy, input bit left, input bit middle,
                              input bit right);
      logic [8:0] dx9;
      logic [8:0] dy9;
      dx9 = 9'(dx);
      dy9 = 9'(dy);
      send_frame(1'b1, {2'b00, dy9[8], dx9[8], 1'b1, middle, right, left}, 1'b0);
      send_frame(1'b1, dx9[7:0], 1'b0);
      exp_x = (exp_x + dx) & 32'hFFF;
      exp_y = (exp_y + dy) & 32'hFFF;
      ms_expect.push_back({left, middle, right, 12'(exp_x), 12'(exp_y)});
      send_frame(1'b1, dy9[7:0], 1'b0);
      assert (ms_expect.size() == 0)
      else check_failed("mouse packet was not reported on ms_ready");
   endtask

   // Compare each ready pulse against the next expected result
   always @(negedge clk)
   begin
      if (!reset && kb_ready)
      begin
         assert (kb_expect.size() != 0)
         else check_failed("kb_ready pulsed with no key word expected");
         exp_word = kb_expect.pop_front();
         assert (kb_data == exp_word)
         else value_mismatch(test_name, 32'(exp_word), 32'(kb_data));
      end
      if (!reset && ms_ready)
      begin
         assert (ms_expect.size() != 0)
         else check_failed("ms_ready pulsed with no mouse packet expected");
         exp_state = ms_expect.pop_front();
         assert ({ms_button, ms_x, ms_y} == exp_state)
         else value_mismatch(test_name, 32'(exp_state), 32'({ms_button, ms_x, ms_y}));
      end
   end

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES)
         check_failed("timeout, the tests did not finish within the cycle limit");
   end

   initial
   begin
      logic [9:0] cmd_bits;
      int         i;
      kb_clk = 1'b1;                     // Lines idle high
      kb_dat = 1'b1;
      ms_clk = 1'b1;
      ms_dat = 1'b1;
      void'($urandom(RAND_SEED));

      @(negedge reset);
      @(negedge clk);
      assert (!kb_ready && !ms_ready)
      else check_failed("ready pulse right after reset");
      assert (kb_data == 16'h0000)
      else value_mismatch(test_name, 32'h0, 32'(kb_data));
      assert ({ms_button, ms_x, ms_y} == 27'h0)
      else value_mismatch(test_name, 32'h0, 32'({ms_button, ms_x, ms_y}));
      assert ({ms_ps2_dir, ms_ps2_clk_out, ms_ps2_data_out} == 3'b101)
      else value_mismatch(test_name, 32'h5, 32'({ms_ps2_dir, ms_ps2_clk_out, ms_ps2_data_out}));
      wait_cycles(1);

      test_name = "mouse_cmd";
      receive_command(cmd_bits);
      assert (cmd_bits[7:0] == ENABLE_CMD)
      else value_mismatch(test_name, 32'(ENABLE_CMD), 32'(cmd_bits[7:0]));
      assert (^cmd_bits[8:0] == 1'b1)
      else check_failed("mouse command parity is not odd");
      assert (cmd_bits[9] == 1'b1)
      else check_failed("mouse command stop bit was not released");
      send_ack();
      assert (ms_ps2_dir == 1'b0)
      else check_failed("host still drives the mouse line after the command");
      send_frame(1'b1, ACK_BYTE, 1'b0);  // Must not reach ms_ready

      test_name = "kb_words";
      for (i = 0; i < 3; i++)
      begin
         send_key(1'b0, 1'b0, random_code());
         send_key(1'b1, 1'b0, random_code());
         send_key(1'b0, 1'b1, random_code());
         send_key(1'b1, 1'b1, random_code());
      end

      test_name = "kb_frame_err";
      send_frame(1'b0, random_code(), 1'b1);
      send_frame(1'b0, EXT_PREFIX, 1'b0);
      send_frame(1'b0, random_code(), 1'b1);
      send_key(1'b0, 1'b0, random_code());  // Extended flag dropped
      send_frame(1'b0, BRK_PREFIX, 1'b0);
      send_frame(1'b0, random_code(), 1'b1);
      send_key(1'b0, 1'b0, random_code());

      test_name = "mouse_packets";
      send_packet(-37, -200, 1'b1, 1'b0, 1'b1);  // Wraps below zero
      for (i = 0; i < 5; i++)
         send_packet(random_delta(), random_delta(), 1'($urandom), 1'($urandom),
                     1'($urandom));

      test_name = "mouse_sync";
      send_frame(1'b1, 8'($urandom) & 8'hF7, 1'b0);
      send_packet(random_delta(), random_delta(), 1'b0, 1'b1, 1'b0);

      wait_cycles(BIT_CYCLES);           // Room for a stray late ready pulse
      $display(">>> PASS");
      $finish;
   end

endmodule

// File: files.f
+incdir+tests
rtl/ps2_pkg.sv
rtl/ps2_line_if.sv
rtl/ps2_frame_rx.sv
rtl/ps2_keyboard.sv
rtl/ps2_mouse_tx.sv
rtl/ps2_mouse.sv
rtl/ps2_result_reg.sv
rtl/ps2_support.sv
tests/ps2_clock_gen.sv
tests/tb_ps2_support.sv

// File: Makefile
# Verilator build for the PS/2 input subsystem
VERILATOR ?= verilator
TOP       ?= tb_ps2_support
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only when the pass line shows up in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
